/* Bender.yml */
package:
  name: mips_top

sources:
  - logic/mips_pkg.sv
  - logic/mips_fetch.sv
  - logic/mips_regfile.sv
  - logic/mips_decode.sv
  - logic/mips_execute.sv
  - logic/mips_memory.sv
  - logic/mips_writeback.sv
  - logic/mips_top.sv
  - target: simulation
    files:
      - testbench/mips_tb.sv

/* logic/mips_decode.sv */
module mips_decode (
    input  logic clk,
    input  logic reset_i,
    input  logic data_stall_i,
    input  mips_pkg::instr_t instr_i,
    input  logic [mips_pkg::XLEN-1:0] pc_i,
    input  logic [mips_pkg::XLEN-1:0] rs_data_i,
    input  logic [mips_pkg::XLEN-1:0] rt_data_i,
    output logic load_use_stall_o,
    input  logic [mips_pkg::REG_ADDR_W-1:0] ex_fwd_dest_i,
    input  logic ex_fwd_write_enable_i,
    input  logic ex_fwd_load_i,
    input  logic [mips_pkg::XLEN-1:0] ex_fwd_data_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] mem_fwd_dest_i,
    input  logic mem_fwd_write_enable_i,
    input  logic mem_fwd_load_i,
    input  logic [mips_pkg::XLEN-1:0] mem_fwd_data_i,
    output logic [mips_pkg::XLEN-1:0] ex_pc_o,
    output logic [mips_pkg::ALU_OP_W-1:0] ex_alu_op_o,
    output logic [mips_pkg::XLEN-1:0] ex_src_a_o,
    output logic [mips_pkg::XLEN-1:0] ex_src_b_o,
    output logic [mips_pkg::XLEN-1:0] ex_store_data_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] ex_dest_o,
    output logic ex_write_enable_o,
    output logic ex_load_o,
    output logic ex_store_o
);

    logic [mips_pkg::XLEN-1:0] rs_val, rt_val, src_b;
    logic [mips_pkg::XLEN-1:0] imm_sext, imm_zext, imm_upper;
    logic [mips_pkg::ALU_OP_W-1:0] alu_op;
    logic [mips_pkg::REG_ADDR_W-1:0] dest;
    logic valid, uses_rs, uses_rt, is_load, is_store, write_enable;

    // execute stage wins over memory stage
    function automatic logic [mips_pkg::XLEN-1:0] fwd_operand(
        input logic [mips_pkg::REG_ADDR_W-1:0] addr,
        input logic [mips_pkg::XLEN-1:0] rf_data
    );
        if (ex_fwd_write_enable_i && ex_fwd_dest_i == addr) begin
            return ex_fwd_data_i;
        end
        if (mem_fwd_write_enable_i && mem_fwd_dest_i == addr) begin
            return mem_fwd_data_i;
        end
        return rf_data;
    endfunction

    function automatic logic load_pending(input logic [mips_pkg::REG_ADDR_W-1:0] addr);
        return (ex_fwd_load_i && ex_fwd_write_enable_i && ex_fwd_dest_i == addr) ||
               (mem_fwd_load_i && mem_fwd_write_enable_i && mem_fwd_dest_i == addr);
    endfunction

    assign imm_sext = {{16{instr_i.i.imm16[15]}}, instr_i.i.imm16};
    assign imm_zext = {16'h0000, instr_i.i.imm16};
    assign imm_upper = {instr_i.i.imm16, 16'h0000};

    always_comb begin
        rs_val = fwd_operand(instr_i.i.rs, rs_data_i);
        rt_val = fwd_operand(instr_i.i.rt, rt_data_i);
        load_use_stall_o = (valid && uses_rs && load_pending(instr_i.i.rs)) ||
                           (valid && uses_rt && load_pending(instr_i.i.rt));
    end

    always_comb begin
        alu_op = mips_pkg::ALU_ADD;
        src_b = imm_sext;
        dest = instr_i.i.rt;
        valid = 1'b1;
        uses_rs = 1'b1;
        uses_rt = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        case (instr_i.r.opcode)
            mips_pkg::OP_SPECIAL: begin
                src_b = rt_val;
                dest = instr_i.r.rd;
                uses_rt = 1'b1;
                case (instr_i.r.funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR: alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR: alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
                    default: valid = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: alu_op = mips_pkg::ALU_ADD;
            mips_pkg::OP_ORI: begin
                alu_op = mips_pkg::ALU_OR;
                src_b = imm_zext;
            end
            mips_pkg::OP_LUI: begin
                alu_op = mips_pkg::ALU_LUI;
                src_b = imm_upper;
                uses_rs = 1'b0;
            end
            mips_pkg::OP_LW: is_load = 1'b1;
            mips_pkg::OP_SW: begin
                is_store = 1'b1;
                uses_rt = 1'b1;
            end
            default: valid = 1'b0;
        endcase
        write_enable = valid && !is_store && dest != '0;
    end

    // a load-use stall sends a bubble, data stall freezes the register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_write_enable_o <= 1'b0;
            ex_load_o <= 1'b0;
            ex_store_o <= 1'b0;
        end else if (!data_stall_i) begin
            ex_write_enable_o <= write_enable && !load_use_stall_o;
            ex_load_o <= is_load && !load_use_stall_o;
            ex_store_o <= is_store && !load_use_stall_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!data_stall_i) begin
            ex_pc_o <= pc_i;
            ex_alu_op_o <= alu_op;
            ex_src_a_o <= rs_val;
            ex_src_b_o <= src_b;
            ex_store_data_o <= rt_val;
            ex_dest_o <= dest;
        end
    end

endmodule

/* logic/mips_execute.sv */
module mips_execute (
    input  logic clk,
    input  logic reset_i,
    input  logic data_stall_i,
    input  logic [mips_pkg::XLEN-1:0] ex_pc_i,
    input  logic [mips_pkg::ALU_OP_W-1:0] ex_alu_op_i,
    input  logic [mips_pkg::XLEN-1:0] ex_src_a_i,
    input  logic [mips_pkg::XLEN-1:0] ex_src_b_i,
    input  logic [mips_pkg::XLEN-1:0] ex_store_data_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] ex_dest_i,
    input  logic ex_write_enable_i,
    input  logic ex_load_i,
    input  logic ex_store_i,
    output logic [mips_pkg::XLEN-1:0] result_o,
    output logic [mips_pkg::XLEN-1:0] mem_pc_o,
    output logic [mips_pkg::XLEN-1:0] mem_result_o,
    output logic [mips_pkg::XLEN-1:0] mem_store_data_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] mem_dest_o,
    output logic mem_write_enable_o,
    output logic mem_load_o,
    output logic mem_store_o
);

    // loads and stores use the add path for the byte address
    always_comb begin
        case (ex_alu_op_i)
            mips_pkg::ALU_ADD: result_o = ex_src_a_i + ex_src_b_i;
            mips_pkg::ALU_SUB: result_o = ex_src_a_i - ex_src_b_i;
            mips_pkg::ALU_AND: result_o = ex_src_a_i & ex_src_b_i;
            mips_pkg::ALU_OR: result_o = ex_src_a_i | ex_src_b_i;
            mips_pkg::ALU_XOR: result_o = ex_src_a_i ^ ex_src_b_i;
            mips_pkg::ALU_SLT:
                result_o = mips_pkg::XLEN'($signed(ex_src_a_i) < $signed(ex_src_b_i));
            mips_pkg::ALU_LUI: result_o = ex_src_b_i;
            default: result_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_write_enable_o <= 1'b0;
            mem_load_o <= 1'b0;
            mem_store_o <= 1'b0;
        end else if (!data_stall_i) begin
            mem_write_enable_o <= ex_write_enable_i;
            mem_load_o <= ex_load_i;
            mem_store_o <= ex_store_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!data_stall_i) begin
            mem_pc_o <= ex_pc_i;
            mem_result_o <= result_o;
            mem_store_data_o <= ex_store_data_i;
            mem_dest_o <= ex_dest_i;
        end
    end

endmodule

/* logic/mips_fetch.sv */
module mips_fetch (
    input  logic clk,
    input  logic reset_i,
    input  logic stall_i,
    input  logic [mips_pkg::XLEN-1:0] inst_sram_rdata_i,
    output logic [mips_pkg::XLEN-1:0] pc_o,
    output mips_pkg::instr_t id_instr_o,
    output logic [mips_pkg::XLEN-1:0] id_pc_o
);

    // the SRAM answers pc_o in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= mips_pkg::RESET_PC;
            id_instr_o <= '0;
        end else if (!stall_i) begin
            pc_o <= pc_o + mips_pkg::XLEN'(4);
            id_instr_o <= inst_sram_rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            id_pc_o <= pc_o;
        end
    end

endmodule

/* logic/mips_memory.sv */
module mips_memory (
    input  logic clk,
    input  logic reset_i,
    input  logic data_stall_i,
    input  logic [mips_pkg::XLEN-1:0] mem_pc_i,
    input  logic [mips_pkg::XLEN-1:0] mem_result_i,
    input  logic [mips_pkg::XLEN-1:0] mem_store_data_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] mem_dest_i,
    input  logic mem_write_enable_i,
    input  logic mem_load_i,
    input  logic mem_store_i,
    output logic data_sram_read_enable_o,
    output logic [3:0] data_sram_wen_o,
    output logic [mips_pkg::XLEN-1:0] data_sram_addr_o,
    output logic [mips_pkg::XLEN-1:0] data_sram_wdata_o,
    output logic [mips_pkg::XLEN-1:0] wb_pc_o,
    output logic [mips_pkg::XLEN-1:0] wb_result_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] wb_dest_o,
    output logic wb_write_enable_o,
    output logic wb_load_o
);

    // request repeats while stalled, but the store only lands once
    assign data_sram_read_enable_o = mem_load_i;
    assign data_sram_wen_o = (mem_store_i && !data_stall_i) ? 4'hf : 4'h0;
    assign data_sram_addr_o = mem_result_i;
    assign data_sram_wdata_o = mem_store_data_i;

    always_ff @(posedge clk) begin
        if (reset_i || data_stall_i) begin
            wb_write_enable_o <= 1'b0;
            wb_load_o <= 1'b0;
        end else begin
            wb_write_enable_o <= mem_write_enable_i;
            wb_load_o <= mem_load_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc_o <= mem_pc_i;
        wb_result_o <= mem_result_i;
        wb_dest_o <= mem_dest_i;
    end

endmodule

/* logic/mips_pkg.sv */
package mips_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W = 3;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI = 6'h0d;
    localparam logic [5:0] OP_LUI = 6'h0f;
    localparam logic [5:0] OP_LW = 6'h23;
    localparam logic [5:0] OP_SW = 6'h2b;

    // function field of SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;

    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;
    // operand b already holds imm << 16
    localparam logic [ALU_OP_W-1:0] ALU_LUI = 3'd6;

    // same word seen as register format or immediate format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [REG_ADDR_W-1:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0] opcode;
            logic [REG_ADDR_W-1:0] rs;
            logic [REG_ADDR_W-1:0] rt;
            logic [15:0] imm16;
        } i;
    } instr_t;

endpackage

/* logic/mips_regfile.sv */
module mips_regfile (
    input  logic clk,
    input  logic reset_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic wr_enable_i,
    input  logic [mips_pkg::XLEN-1:0] wr_data_i,
    output logic [mips_pkg::XLEN-1:0] rs_data_o,
    output logic [mips_pkg::XLEN-1:0] rt_data_o
);

    logic [mips_pkg::XLEN-1:0] regs [1:31];

    // r0 reads zero, a write in flight is seen at once
    function automatic logic [mips_pkg::XLEN-1:0] read_reg(
        input logic [mips_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        if (wr_enable_i && wr_addr_i == addr) begin
            return wr_data_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (wr_enable_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_comb begin
        rs_data_o = read_reg(rs_addr_i);
        rt_data_o = read_reg(rt_addr_i);
    end

endmodule

/* logic/mips_top.sv */
module mips_top (
    input  logic clk,
    input  logic reset_i,
    output logic [mips_pkg::XLEN-1:0] inst_sram_addr_o,
    input  logic [mips_pkg::XLEN-1:0] inst_sram_rdata_i,
    output logic data_sram_read_enable_o,
    output logic [3:0] data_sram_wen_o,
    output logic [mips_pkg::XLEN-1:0] data_sram_addr_o,
    output logic [mips_pkg::XLEN-1:0] data_sram_wdata_o,
    input  logic [mips_pkg::XLEN-1:0] data_sram_rdata_i,
    input  logic data_stall_i,
    output logic [mips_pkg::XLEN-1:0] debug_wb_pc_o,
    output logic [3:0] debug_wb_wen_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_num_o,
    output logic [mips_pkg::XLEN-1:0] debug_wb_data_o
);

    mips_pkg::instr_t id_instr;
    logic [mips_pkg::XLEN-1:0] id_pc, rs_data, rt_data;
    logic load_use_stall;

    logic [mips_pkg::XLEN-1:0] ex_pc, ex_src_a, ex_src_b, ex_store_data, ex_result;
    logic [mips_pkg::ALU_OP_W-1:0] ex_alu_op;
    logic [mips_pkg::REG_ADDR_W-1:0] ex_dest;
    logic ex_write_enable, ex_load, ex_store;

    logic [mips_pkg::XLEN-1:0] mem_pc, mem_result, mem_store_data;
    logic [mips_pkg::REG_ADDR_W-1:0] mem_dest;
    logic mem_write_enable, mem_load, mem_store;

    logic [mips_pkg::XLEN-1:0] wb_pc, wb_result, rf_wr_data;
    logic [mips_pkg::REG_ADDR_W-1:0] wb_dest, rf_wr_addr;
    logic wb_write_enable, wb_load, rf_wr_enable;

    mips_fetch fetch_stage (
        .clk(clk),
        .reset_i(reset_i),
        .stall_i(load_use_stall | data_stall_i),
        .inst_sram_rdata_i(inst_sram_rdata_i),
        .pc_o(inst_sram_addr_o),
        .id_instr_o(id_instr),
        .id_pc_o(id_pc)
    );

    mips_regfile regfile (
        .clk(clk),
        .reset_i(reset_i),
        .rs_addr_i(id_instr.r.rs),
        .rt_addr_i(id_instr.r.rt),
        .wr_addr_i(rf_wr_addr),
        .wr_enable_i(rf_wr_enable),
        .wr_data_i(rf_wr_data),
        .rs_data_o(rs_data),
        .rt_data_o(rt_data)
    );

    mips_decode decode_stage (
        .clk(clk),
        .reset_i(reset_i),
        .data_stall_i(data_stall_i),
        .instr_i(id_instr),
        .pc_i(id_pc),
        .rs_data_i(rs_data),
        .rt_data_i(rt_data),
        .load_use_stall_o(load_use_stall),
        .ex_fwd_dest_i(ex_dest),
        .ex_fwd_write_enable_i(ex_write_enable),
        .ex_fwd_load_i(ex_load),
        .ex_fwd_data_i(ex_result),
        .mem_fwd_dest_i(mem_dest),
        .mem_fwd_write_enable_i(mem_write_enable),
        .mem_fwd_load_i(mem_load),
        .mem_fwd_data_i(mem_result),
        .ex_pc_o(ex_pc),
        .ex_alu_op_o(ex_alu_op),
        .ex_src_a_o(ex_src_a),
        .ex_src_b_o(ex_src_b),
        .ex_store_data_o(ex_store_data),
        .ex_dest_o(ex_dest),
        .ex_write_enable_o(ex_write_enable),
        .ex_load_o(ex_load),
        .ex_store_o(ex_store)
    );

    mips_execute execute_stage (
        .clk(clk),
        .reset_i(reset_i),
        .data_stall_i(data_stall_i),
        .ex_pc_i(ex_pc),
        .ex_alu_op_i(ex_alu_op),
        .ex_src_a_i(ex_src_a),
        .ex_src_b_i(ex_src_b),
        .ex_store_data_i(ex_store_data),
        .ex_dest_i(ex_dest),
        .ex_write_enable_i(ex_write_enable),
        .ex_load_i(ex_load),
        .ex_store_i(ex_store),
        .result_o(ex_result),
        .mem_pc_o(mem_pc),
        .mem_result_o(mem_result),
        .mem_store_data_o(mem_store_data),
        .mem_dest_o(mem_dest),
        .mem_write_enable_o(mem_write_enable),
        .mem_load_o(mem_load),
        .mem_store_o(mem_store)
    );

    mips_memory memory_stage (
        .clk(clk),
        .reset_i(reset_i),
        .data_stall_i(data_stall_i),
        .mem_pc_i(mem_pc),
        .mem_result_i(mem_result),
        .mem_store_data_i(mem_store_data),
        .mem_dest_i(mem_dest),
        .mem_write_enable_i(mem_write_enable),
        .mem_load_i(mem_load),
        .mem_store_i(mem_store),
        .data_sram_read_enable_o(data_sram_read_enable_o),
        .data_sram_wen_o(data_sram_wen_o),
        .data_sram_addr_o(data_sram_addr_o),
        .data_sram_wdata_o(data_sram_wdata_o),
        .wb_pc_o(wb_pc),
        .wb_result_o(wb_result),
        .wb_dest_o(wb_dest),
        .wb_write_enable_o(wb_write_enable),
        .wb_load_o(wb_load)
    );

    mips_writeback writeback_stage (
        .wb_pc_i(wb_pc),
        .wb_result_i(wb_result),
        .wb_dest_i(wb_dest),
        .wb_write_enable_i(wb_write_enable),
        .wb_load_i(wb_load),
        .data_sram_rdata_i(data_sram_rdata_i),
        .rf_wr_enable_o(rf_wr_enable),
        .rf_wr_addr_o(rf_wr_addr),
        .rf_wr_data_o(rf_wr_data),
        .debug_wb_pc_o(debug_wb_pc_o),
        .debug_wb_wen_o(debug_wb_wen_o),
        .debug_wb_num_o(debug_wb_num_o),
        .debug_wb_data_o(debug_wb_data_o)
    );

endmodule

/* logic/mips_writeback.sv */
module mips_writeback (
    input  logic [mips_pkg::XLEN-1:0] wb_pc_i,
    input  logic [mips_pkg::XLEN-1:0] wb_result_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0] wb_dest_i,
    input  logic wb_write_enable_i,
    input  logic wb_load_i,
    input  logic [mips_pkg::XLEN-1:0] data_sram_rdata_i,
    output logic rf_wr_enable_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] rf_wr_addr_o,
    output logic [mips_pkg::XLEN-1:0] rf_wr_data_o,
    output logic [mips_pkg::XLEN-1:0] debug_wb_pc_o,
    output logic [3:0] debug_wb_wen_o,
    output logic [mips_pkg::REG_ADDR_W-1:0] debug_wb_num_o,
    output logic [mips_pkg::XLEN-1:0] debug_wb_data_o
);

    // load data arrives from the SRAM in this cycle
    assign rf_wr_data_o = wb_load_i ? data_sram_rdata_i : wb_result_i;
    assign rf_wr_enable_o = wb_write_enable_i;
    assign rf_wr_addr_o = wb_dest_i;

    assign debug_wb_pc_o = wb_pc_i;
    assign debug_wb_wen_o = {4{wb_write_enable_i}};
    assign debug_wb_num_o = wb_dest_i;
    assign debug_wb_data_o = rf_wr_data_o;

endmodule

/* mips_top.f */
logic/mips_pkg.sv
logic/mips_fetch.sv
logic/mips_regfile.sv
logic/mips_decode.sv
logic/mips_execute.sv
logic/mips_memory.sv
logic/mips_writeback.sv
logic/mips_top.sv
testbench/mips_tb.sv

/* testbench/mips_tb.sv */
module mips_tb;

    localparam int CLK_PERIOD = 100;
    localparam int PROG_LEN = 400;
    localparam int DMEM_WORDS = 64;
    localparam int RESET_CYCLES = 4;
    localparam int DRAIN_CYCLES = 20;
    localparam int WATCHDOG_CYCLES = PROG_LEN * 8 + 100;
    localparam logic [31:0] SEED = 32'h728c;

    logic clk;
    logic reset_i;
    logic data_stall_i;
    logic [31:0] inst_sram_addr_o;
    logic [31:0] inst_sram_rdata_i;
    logic data_sram_read_enable_o;
    logic [3:0] data_sram_wen_o;
    logic [31:0] data_sram_addr_o;
    logic [31:0] data_sram_wdata_o;
    logic [31:0] data_sram_rdata_i;
    logic [31:0] debug_wb_pc_o;
    logic [3:0] debug_wb_wen_o;
    logic [4:0] debug_wb_num_o;
    logic [31:0] debug_wb_data_o;

    logic [31:0] imem [0:PROG_LEN-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] rng_state = SEED;

    // expected commits and stores from the ISA model, oldest first
    logic [31:0] exp_commit_pc [$];
    logic [4:0] exp_commit_num [$];
    logic [31:0] exp_commit_data [$];
    logic [31:0] exp_store_addr [$];
    logic [31:0] exp_store_data [$];
    int commits_total = 0;
    int stores_total = 0;
    int commits_seen = 0;
    int stores_seen = 0;

    mips_top dut (
        .clk(clk),
        .reset_i(reset_i),
        .inst_sram_addr_o(inst_sram_addr_o),
        .inst_sram_rdata_i(inst_sram_rdata_i),
        .data_sram_read_enable_o(data_sram_read_enable_o),
        .data_sram_wen_o(data_sram_wen_o),
        .data_sram_addr_o(data_sram_addr_o),
        .data_sram_wdata_o(data_sram_wdata_o),
        .data_sram_rdata_i(data_sram_rdata_i),
        .data_stall_i(data_stall_i),
        .debug_wb_pc_o(debug_wb_pc_o),
        .debug_wb_wen_o(debug_wb_wen_o),
        .debug_wb_num_o(debug_wb_num_o),
        .debug_wb_data_o(debug_wb_data_o)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // r0..r7 only, so neighbours depend on each other often
    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = next_rand();
        return {2'b00, r[29:27]};
    endfunction

    function automatic logic [31:0] dmem_fill(input int idx);
        logic [31:0] addr;
        addr = 32'(idx) << 2;
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic build_program();
        mips_pkg::instr_t w;
        logic [31:0] r;
        int kind;
        for (int n = 0; n < PROG_LEN; n++) begin
            r = next_rand();
            kind = int'(r[31:16] % 13);
            w = '0;
            w.i.rs = rand_reg();
            w.i.rt = rand_reg();
            r = next_rand();
            if (kind < 6) begin
                w.r.opcode = mips_pkg::OP_SPECIAL;
                w.r.rd = rand_reg();
                w.r.shamt = 5'd0;
                case (kind)
                    0: w.r.funct = mips_pkg::FN_ADDU;
                    1: w.r.funct = mips_pkg::FN_SUBU;
                    2: w.r.funct = mips_pkg::FN_AND;
                    3: w.r.funct = mips_pkg::FN_OR;
                    4: w.r.funct = mips_pkg::FN_XOR;
                    default: w.r.funct = mips_pkg::FN_SLT;
                endcase
            end else if (kind < 9) begin
                w.i.imm16 = r[31:16];
                case (kind)
                    6: w.i.opcode = mips_pkg::OP_ADDIU;
                    7: w.i.opcode = mips_pkg::OP_ORI;
                    default: w.i.opcode = mips_pkg::OP_LUI;
                endcase
            end else begin
                // base r0 and a word offset below 256
                w.i.opcode = (kind < 11) ? mips_pkg::OP_LW : mips_pkg::OP_SW;
                w.i.rs = 5'd0;
                w.i.imm16 = {8'h00, r[21:16], 2'b00};
            end
            imem[n] = w;
        end
    endtask

    // in-order reference, one instruction at a time
    task automatic run_model();
        mips_pkg::instr_t w;
        logic [31:0] regs [0:31];
        logic [31:0] mem [0:DMEM_WORDS-1];
        logic [31:0] a, b, sext, addr, value;
        logic [4:0] dest;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < DMEM_WORDS; k++) begin
            mem[k] = dmem_fill(k);
        end
        for (int n = 0; n < PROG_LEN; n++) begin
            w = imem[n];
            a = regs[w.i.rs];
            b = regs[w.i.rt];
            sext = {{16{w.i.imm16[15]}}, w.i.imm16};
            addr = a + sext;
            dest = w.i.rt;
            value = '0;
            case (w.i.opcode)
                mips_pkg::OP_SPECIAL: begin
                    dest = w.r.rd;
                    case (w.r.funct)
                        mips_pkg::FN_ADDU: value = a + b;
                        mips_pkg::FN_SUBU: value = a - b;
                        mips_pkg::FN_AND: value = a & b;
                        mips_pkg::FN_OR: value = a | b;
                        mips_pkg::FN_XOR: value = a ^ b;
                        mips_pkg::FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: dest = 5'd0;
                    endcase
                end
                mips_pkg::OP_ADDIU: value = a + sext;
                mips_pkg::OP_ORI: value = a | {16'h0000, w.i.imm16};
                mips_pkg::OP_LUI: value = {w.i.imm16, 16'h0000};
                mips_pkg::OP_LW: value = mem[addr[7:2]];
                mips_pkg::OP_SW: begin
                    dest = 5'd0;
                    mem[addr[7:2]] = b;
                    exp_store_addr.push_back(addr);
                    exp_store_data.push_back(b);
                end
                default: dest = 5'd0;
            endcase
            if (dest != 5'd0) begin
                regs[dest] = value;
                exp_commit_pc.push_back(32'(n) << 2);
                exp_commit_num.push_back(dest);
                exp_commit_data.push_back(value);
            end
        end
        commits_total = exp_commit_pc.size();
        stores_total = exp_store_addr.size();
    endtask

    // addresses past the program read a zero word
    assign inst_sram_rdata_i = ((inst_sram_addr_o[31:2] < PROG_LEN) === 1'b1) ?
                               imem[inst_sram_addr_o[10:2]] : 32'h0;

    // synchronous data memory, read data lands in the next cycle
    always @(posedge clk) begin
        if (data_sram_read_enable_o) begin
            data_sram_rdata_i <= dmem[data_sram_addr_o[7:2]];
        end
        if (data_sram_wen_o == 4'hf) begin
            dmem[data_sram_addr_o[7:2]] <= data_sram_wdata_o;
        end
    end

    always @(posedge clk) begin
        if (!reset_i && debug_wb_wen_o != 4'h0) begin
            assert (commits_seen < commits_total)
            else report_failure("register write seen after all expected commits");
            assert (debug_wb_wen_o == 4'hf && debug_wb_pc_o == exp_commit_pc[0] &&
                    debug_wb_num_o == exp_commit_num[0] &&
                    debug_wb_data_o == exp_commit_data[0])
            else report_mismatch($sformatf(
                "commit pc %h r%0d = %h, expected pc %h r%0d = %h",
                debug_wb_pc_o, debug_wb_num_o, debug_wb_data_o,
                exp_commit_pc[0], exp_commit_num[0], exp_commit_data[0]));
            void'(exp_commit_pc.pop_front());
            void'(exp_commit_num.pop_front());
            void'(exp_commit_data.pop_front());
            commits_seen++;
        end
        if (!reset_i && data_sram_wen_o != 4'h0) begin
            assert (stores_seen < stores_total)
            else report_failure("memory write seen after all expected stores");
            assert (data_sram_wen_o == 4'hf && data_sram_addr_o == exp_store_addr[0] &&
                    data_sram_wdata_o == exp_store_data[0])
            else report_mismatch($sformatf(
                "store [%h] = %h, expected [%h] = %h",
                data_sram_addr_o, data_sram_wdata_o, exp_store_addr[0], exp_store_data[0]));
            void'(exp_store_addr.pop_front());
            void'(exp_store_data.pop_front());
            stores_seen++;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        logic [31:0] r;
        reset_i = 1'b1;
        data_stall_i = 1'b0;
        data_sram_rdata_i = '0;
        build_program();
        for (int k = 0; k < DMEM_WORDS; k++) begin
            dmem[k] = dmem_fill(k);
        end
        run_model();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        assert (inst_sram_addr_o == mips_pkg::RESET_PC && debug_wb_wen_o == 4'h0 &&
                data_sram_wen_o == 4'h0 && data_sram_read_enable_o == 1'b0)
        else report_mismatch($sformatf("state after reset: pc %h wb_wen %h wen %h ren %b",
            inst_sram_addr_o, debug_wb_wen_o, data_sram_wen_o, data_sram_read_enable_o));
        reset_i = 1'b0;
        while (commits_seen < commits_total || stores_seen < stores_total) begin
            @(negedge clk);
            r = next_rand();
            data_stall_i = (r[31:16] % 6 == 0);
        end
        // a few quiet cycles so a repeated commit or store still shows up
        @(negedge clk);
        data_stall_i = 1'b0;
        repeat (DRAIN_CYCLES) @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
